// File: compile.f
+incdir+.
core_csr_pkg.sv
perf_counters.sv
cs_registers.sv
dbg_unit.sv
csr_dbg_top.sv
tb_csr_dbg_top.sv

// File: Bender.yml
package:
  name: csr_dbg

sources:
  - files:
      - core_csr_pkg.sv
      - perf_counters.sv
      - cs_registers.sv
      - dbg_unit.sv
      - csr_dbg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_dbg_top.sv

// File: tb_csr_dbg_tasks.svh
// Drive, compare and directed test tasks, included inside the testbench top module

////////////////////
// Compare tasks
////////////////////

task automatic check_word(input string name, input word_t actual, input word_t expected);
  if (actual !== expected)
  begin
    $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    stop_on_failure();
  end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
  if (actual !== expected)
  begin
    $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
    stop_on_failure();
  end
endtask

// MHARTID layout, cluster in 9:5 and core in 4:0
function automatic word_t hartid_value();
  return (word_t'(cluster_id) << 5) | word_t'(core_id);
endfunction

////////////////////
// Drive tasks
////////////////////

// One core port access, read sampled mid cycle before the op takes effect
task automatic csr_port_access(input csr_op_e op, input csr_addr_t addr, input word_t wdata,
                               output word_t rdata);
  @(posedge clk);
  csr_access_i <= 1'b1;
  csr_op_i     <= op;
  csr_addr_i   <= addr;
  csr_wdata_i  <= wdata;
  @(negedge clk);
  rdata        = csr_rdata_o;     // Value before the op
  sample_cycle = cycle_cnt;
  @(posedge clk);                 // Op lands on this edge
  csr_access_i <= 1'b0;
  csr_op_i     <= CSR_OP_NONE;
endtask

task automatic csr_read_check(input csr_addr_t addr, input word_t expected, input string name);
  word_t v;
  csr_port_access(CSR_OP_NONE, addr, '0, v);
  check_word(name, v, expected);
endtask

// Full strobe/ack transfer, also checks the ack latency and width
task automatic dbg_bus_access(input logic we, input dbg_addr_t addr, input word_t wdata,
                              output word_t rdata);
  int unsigned edges;
  @(posedge clk);
  dbginf_strobe_i <= 1'b1;
  dbginf_we_i     <= we;
  dbginf_addr_i   <= addr;
  dbginf_data_i   <= wdata;
  @(posedge clk);                 // First edge sampling the strobe
  edges = 0;
  @(negedge clk);
  while (!dbginf_ack_o)
  begin
    if (edges == 8)
    begin
      $display("no debug ack 8 cycles after the strobe, time %0t", $time);
      stop_on_failure();
    end
    @(negedge clk);
    edges++;
  end
  check_word("dbginf_ack_o latency", word_t'(edges), 32'd2);
  rdata = dbginf_data_o;          // Valid in the ack cycle
  @(posedge clk);
  dbginf_strobe_i <= 1'b0;        // Drop at the edge that saw the ack
  dbginf_we_i     <= 1'b0;
  @(negedge clk);
  check_bit("dbginf_ack_o after ack cycle", dbginf_ack_o, 1'b0);
endtask

////////////////////
// Directed tests
////////////////////

task automatic read_reset_values();
  csr_read_check(CSR_MSCRATCH, '0, "mscratch after reset");
  csr_read_check(CSR_PCER, '0, "pcer after reset");
  csr_read_check(CSR_PCCR_CYCLE, '0, "cycle counter after reset");
  csr_read_check(CSR_PCCR_LOAD, '0, "load counter after reset");
  csr_read_check(CSR_PCCR_STORE, '0, "store counter after reset");
  csr_read_check(CSR_PCCR_EXT0, '0, "ext0 counter after reset");
  csr_read_check(csr_addr_t'(CSR_PCCR_EXT0 + 1), '0, "ext1 counter after reset");
  csr_read_check(CSR_MHARTID, hartid_value(), "mhartid");
  check_bit("dbg_stall_o after reset", dbg_stall_o, 1'b0);
endtask

task automatic exercise_mscratch_ops();
  word_t a;
  word_t b;
  word_t c;
  word_t v;
  a = $random(seed);
  b = $random(seed);
  c = $random(seed);
  csr_port_access(CSR_OP_WRITE, CSR_MSCRATCH, a, v);
  check_word("mscratch before write", v, '0);
  csr_read_check(CSR_MSCRATCH, a, "mscratch after write");
  csr_port_access(CSR_OP_SET, CSR_MSCRATCH, b, v);
  check_word("mscratch before set", v, a);
  csr_port_access(CSR_OP_CLEAR, CSR_MSCRATCH, c, v);
  check_word("mscratch before clear", v, a | b);
  csr_read_check(CSR_MSCRATCH, (a | b) & ~c, "mscratch after clear");
  // Read only register keeps the ids
  csr_port_access(CSR_OP_WRITE, CSR_MHARTID, a, v);
  check_word("mhartid before write", v, hartid_value());
  csr_read_check(CSR_MHARTID, hartid_value(), "mhartid after write");
endtask

task automatic halt_and_release();
  word_t v;
  dbg_bus_access(1'b1, DBG_ADDR_CTRL, 32'd1, v);   // Halt request
  check_bit("dbg_stall_o after halt", dbg_stall_o, 1'b1);
  dbg_bus_access(1'b0, DBG_ADDR_CTRL, '0, v);
  check_word("debug ctrl read", v, 32'd1);
  dbg_bus_access(1'b1, DBG_ADDR_CTRL, '0, v);      // Release
  check_bit("dbg_stall_o after release", dbg_stall_o, 1'b0);
  @(posedge clk);
  dbginf_stall_i <= 1'b1;
  @(negedge clk);
  check_bit("dbg_stall_o from dbginf_stall_i", dbg_stall_o, 1'b1);
  @(posedge clk);
  dbginf_stall_i <= 1'b0;
  @(negedge clk);
  check_bit("dbg_stall_o after dbginf_stall_i low", dbg_stall_o, 1'b0);
endtask

task automatic access_csr_via_debug();
  word_t     d;
  word_t     v;
  dbg_addr_t scratch_addr;
  scratch_addr = dbg_addr_t'(1 << DBG_CSR_BIT) | dbg_addr_t'(CSR_MSCRATCH);
  d            = $random(seed);
  dbg_bus_access(1'b1, DBG_ADDR_CTRL, 32'd1, v);   // Halt first
  dbg_bus_access(1'b1, scratch_addr, d, v);
  dbg_bus_access(1'b0, scratch_addr, '0, v);
  check_word("debug mscratch read while halted", v, d);
  dbg_bus_access(1'b1, DBG_ADDR_CTRL, '0, v);
  csr_read_check(CSR_MSCRATCH, d, "mscratch after debug write");
  // Core running, CSR space reads 0 and drops writes
  dbg_bus_access(1'b0, scratch_addr, '0, v);
  check_word("debug mscratch read while running", v, '0);
  dbg_bus_access(1'b1, scratch_addr, ~d, v);
  csr_read_check(CSR_MSCRATCH, d, "mscratch after dropped debug write");
endtask

task automatic count_bus_events();
  word_t                     v;
  word_t                     v1;
  logic [31:0]               r;
  logic                      req;
  logic                      gnt;
  logic                      we;
  logic [n_ext_counters-1:0] ext;
  int unsigned               n_cyc;
  int unsigned               gap;
  int unsigned               loads;
  int unsigned               stores;
  int unsigned               pulses;
  int unsigned               c1;
  loads  = 0;
  stores = 0;
  pulses = 0;
  csr_port_access(CSR_OP_WRITE, CSR_PCER, 32'h1E, v);  // Loads, stores, ext0, ext1
  csr_read_check(CSR_PCER, 32'h1E, "pcer");
  n_cyc = 12 + ($unsigned($random(seed)) % 12);
  for (int i = 0; i < n_cyc; i++)
  begin
    r   = $random(seed);
    req = r[0];
    gnt = r[1];
    we  = r[2];
    if (i % 4 == 0)
    begin
      req = 1'b1;                 // Request left without grant
      gnt = 1'b0;
    end
    ext = '0;
    if (i == 2 || i == 5)
      ext[0] = 1'b1;              // Two single cycle pulses
    if (req && gnt && we)
      stores++;
    if (req && gnt && !we)
      loads++;
    pulses += ext[0];
    @(posedge clk);
    data_req_i          <= req;
    data_gnt_i          <= gnt;
    data_we_i           <= we;
    ext_perf_counters_i <= ext;
  end
  @(posedge clk);
  data_req_i          <= 1'b0;
  data_gnt_i          <= 1'b0;
  data_we_i           <= 1'b0;
  ext_perf_counters_i <= '0;
  csr_read_check(CSR_PCCR_LOAD, word_t'(loads), "load counter");
  csr_read_check(CSR_PCCR_STORE, word_t'(stores), "store counter");
  csr_read_check(CSR_PCCR_EXT0, word_t'(pulses), "ext0 counter");
  csr_read_check(csr_addr_t'(CSR_PCCR_EXT0 + 1), '0, "ext1 counter");
  csr_read_check(CSR_PCCR_CYCLE, '0, "cycle counter while disabled");
  // Cycle counter on, two reads a random gap apart
  csr_port_access(CSR_OP_SET, CSR_PCER, 32'h1, v);
  csr_port_access(CSR_OP_NONE, CSR_PCCR_CYCLE, '0, v1);
  c1  = sample_cycle;
  gap = 3 + ($unsigned($random(seed)) % 8);
  repeat (gap) @(posedge clk);
  csr_port_access(CSR_OP_NONE, CSR_PCCR_CYCLE, '0, v);
  check_word("cycle counter delta", v - v1, word_t'(sample_cycle - c1));
endtask

// File: tb_csr_dbg_top.sv
// Testbench top for the control and status slice, runs the directed CSR, debug and counter tests
`timescale 1ns/1ps

module tb_csr_dbg_top;

  import core_csr_pkg::*;

  localparam int unsigned n_ext_counters = 2;
  localparam int unsigned timeout_cycles = 600;     // Roughly twice the full sequence
  localparam hart_id_t    core_id        = 5'h0B;
  localparam hart_id_t    cluster_id     = 5'h15;

  logic                      clk;
  logic                      rst_n;
  hart_id_t                  core_id_i;
  hart_id_t                  cluster_id_i;

  // Execute stage CSR port
  logic                      csr_access_i;
  csr_op_e                   csr_op_i;
  csr_addr_t                 csr_addr_i;
  word_t                     csr_wdata_i;
  word_t                     csr_rdata_o;

  // Observed data bus and external events
  logic                      data_req_i;
  logic                      data_gnt_i;
  logic                      data_we_i;
  logic [n_ext_counters-1:0] ext_perf_counters_i;

  // Debug bus
  logic                      dbginf_stall_i;
  logic                      dbginf_strobe_i;
  logic                      dbginf_we_i;
  dbg_addr_t                 dbginf_addr_i;
  word_t                     dbginf_data_i;
  logic                      dbginf_ack_o;
  word_t                     dbginf_data_o;
  logic                      dbg_stall_o;

  int                        seed         = 6505;
  int unsigned               cycle_cnt    = 0;
  int unsigned               sample_cycle = 0;  // Cycle of the last core port sample

  always #4 clk = ~clk;  // 8 ns period

  csr_dbg_top
  #(
    .n_ext_counters      ( n_ext_counters      )
  )
  i_csr_dbg_top
  (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .core_id_i           ( core_id_i           ),
    .cluster_id_i        ( cluster_id_i        ),
    .csr_access_i        ( csr_access_i        ),
    .csr_op_i            ( csr_op_i            ),
    .csr_addr_i          ( csr_addr_i          ),
    .csr_wdata_i         ( csr_wdata_i         ),
    .csr_rdata_o         ( csr_rdata_o         ),
    .data_req_i          ( data_req_i          ),
    .data_gnt_i          ( data_gnt_i          ),
    .data_we_i           ( data_we_i           ),
    .ext_perf_counters_i ( ext_perf_counters_i ),
    .dbginf_stall_i      ( dbginf_stall_i      ),
    .dbginf_strobe_i     ( dbginf_strobe_i     ),
    .dbginf_we_i         ( dbginf_we_i         ),
    .dbginf_addr_i       ( dbginf_addr_i       ),
    .dbginf_data_i       ( dbginf_data_i       ),
    .dbginf_ack_o        ( dbginf_ack_o        ),
    .dbginf_data_o       ( dbginf_data_o       ),
    .dbg_stall_o         ( dbg_stall_o         )
  );

  // Ends the run after the error line has been printed
  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "tb_csr_dbg_tasks.svh"

  ////////////////////
  // Watchdog
  ////////////////////

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles)
    begin
      $display("timeout, test sequence still running after %0d cycles", timeout_cycles);
      stop_on_failure();
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial
  begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    core_id_i           = core_id;
    cluster_id_i        = cluster_id;
    csr_access_i        = 1'b0;
    csr_op_i            = CSR_OP_NONE;
    csr_addr_i          = '0;
    csr_wdata_i         = '0;
    data_req_i          = 1'b0;
    data_gnt_i          = 1'b0;
    data_we_i           = 1'b0;
    ext_perf_counters_i = '0;
    dbginf_stall_i      = 1'b0;
    dbginf_strobe_i     = 1'b0;
    dbginf_we_i         = 1'b0;
    dbginf_addr_i       = '0;
    dbginf_data_i       = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;                  // Released after 3 cycles

    read_reset_values();
    exercise_mscratch_ops();
    halt_and_release();
    access_csr_via_debug();
    count_bus_events();

    repeat (2) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: csr_dbg_top.sv
// Control and status top level joining the debug unit and the CSR file, instantiated by the core
`timescale 1ns/1ps

module csr_dbg_top
#(
  parameter int unsigned n_ext_counters = 2
)
(
  input  logic                          clk,
  input  logic                          rst_n,

  input  core_csr_pkg::hart_id_t        core_id_i,
  input  core_csr_pkg::hart_id_t        cluster_id_i,

  // Execute stage CSR port
  input  logic                          csr_access_i,
  input  core_csr_pkg::csr_op_e         csr_op_i,
  input  core_csr_pkg::csr_addr_t       csr_addr_i,
  input  core_csr_pkg::word_t           csr_wdata_i,
  output core_csr_pkg::word_t           csr_rdata_o,

  // Observed data bus
  input  logic                          data_req_i,
  input  logic                          data_gnt_i,
  input  logic                          data_we_i,

  input  logic [n_ext_counters-1:0]     ext_perf_counters_i,

  // Debug bus
  input  logic                          dbginf_stall_i,
  input  logic                          dbginf_strobe_i,
  input  logic                          dbginf_we_i,
  input  core_csr_pkg::dbg_addr_t       dbginf_addr_i,
  input  core_csr_pkg::word_t           dbginf_data_i,
  output logic                          dbginf_ack_o,
  output core_csr_pkg::word_t           dbginf_data_o,

  output logic                          dbg_stall_o
);

  import core_csr_pkg::*;

  // Debug to CSR file
  logic      dbg_csr_req;
  logic      dbg_csr_we;
  csr_addr_t dbg_csr_addr;
  word_t     dbg_csr_wdata;
  word_t     dbg_csr_rdata;

  ////////////////////
  // Debug unit
  ////////////////////

  dbg_unit i_dbg_unit
  (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .dbginf_stall_i  ( dbginf_stall_i  ),
    .dbginf_strobe_i ( dbginf_strobe_i ),
    .dbginf_we_i     ( dbginf_we_i     ),
    .dbginf_addr_i   ( dbginf_addr_i   ),
    .dbginf_data_i   ( dbginf_data_i   ),
    .dbginf_ack_o    ( dbginf_ack_o    ),
    .dbginf_data_o   ( dbginf_data_o   ),
    .dbg_stall_o     ( dbg_stall_o     ),
    .dbg_csr_req_o   ( dbg_csr_req     ),
    .dbg_csr_we_o    ( dbg_csr_we      ),
    .dbg_csr_addr_o  ( dbg_csr_addr    ),
    .dbg_csr_wdata_o ( dbg_csr_wdata   ),
    .dbg_csr_rdata_i ( dbg_csr_rdata   )
  );

  ////////////////////
  // CSR file
  ////////////////////

  cs_registers
  #(
    .n_ext_counters      ( n_ext_counters      )
  )
  i_cs_registers
  (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .core_id_i           ( core_id_i           ),
    .cluster_id_i        ( cluster_id_i        ),
    .csr_access_i        ( csr_access_i        ),
    .csr_op_i            ( csr_op_i            ),
    .csr_addr_i          ( csr_addr_i          ),
    .csr_wdata_i         ( csr_wdata_i         ),
    .csr_rdata_o         ( csr_rdata_o         ),
    .dbg_csr_req_i       ( dbg_csr_req         ),
    .dbg_csr_we_i        ( dbg_csr_we          ),
    .dbg_csr_addr_i      ( dbg_csr_addr        ),
    .dbg_csr_wdata_i     ( dbg_csr_wdata       ),
    .dbg_csr_rdata_o     ( dbg_csr_rdata       ),
    .data_req_i          ( data_req_i          ),
    .data_gnt_i          ( data_gnt_i          ),
    .data_we_i           ( data_we_i           ),
    .ext_perf_counters_i ( ext_perf_counters_i )
  );

endmodule

// File: dbg_unit.sv
// Debug bus slave with the halt control register and CSR access sequencing, used by the top level
`timescale 1ns/1ps

module dbg_unit
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Debug bus
  input  logic                          dbginf_stall_i,
  input  logic                          dbginf_strobe_i,
  input  logic                          dbginf_we_i,
  input  core_csr_pkg::dbg_addr_t       dbginf_addr_i,
  input  core_csr_pkg::word_t           dbginf_data_i,
  output logic                          dbginf_ack_o,
  output core_csr_pkg::word_t           dbginf_data_o,

  output logic                          dbg_stall_o,    // Halts the core

  // CSR port towards the CSR file
  output logic                          dbg_csr_req_o,
  output logic                          dbg_csr_we_o,
  output core_csr_pkg::csr_addr_t       dbg_csr_addr_o,
  output core_csr_pkg::word_t           dbg_csr_wdata_o,
  input  core_csr_pkg::word_t           dbg_csr_rdata_i
);

  import core_csr_pkg::*;

  dbg_state_e state_q;
  dbg_state_e state_d;
  logic       halt_q;      // Halt request from ctrl reg
  logic       ack_q;
  word_t      rdata_q;     // Read data for the ack cycle
  logic       csr_space;
  logic       ctrl_space;

  assign csr_space   = dbginf_addr_i[DBG_CSR_BIT];
  assign ctrl_space  = (dbginf_addr_i == DBG_ADDR_CTRL);
  assign dbg_stall_o = halt_q | dbginf_stall_i;  // Either source halts

  ////////////////////
  // Handshake FSM
  ////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      DBG_IDLE:
      begin
        if (dbginf_strobe_i)
          state_d = DBG_ACCESS;
      end
      DBG_ACCESS:  state_d = DBG_ACK;
      DBG_ACK:     state_d = DBG_RELEASE;   // Ack registered on this edge
      DBG_RELEASE:
      begin
        if (!dbginf_strobe_i)
          state_d = DBG_IDLE;               // Requester saw the ack
      end
      default:     state_d = DBG_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= DBG_IDLE;
      halt_q  <= 1'b0;
      ack_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      ack_q   <= (state_q == DBG_ACK);      // Single cycle pulse
      if (state_q == DBG_ACCESS && dbginf_we_i && ctrl_space)
        halt_q <= dbginf_data_i[0];
    end
  end

  // Capture read data at the end of the access cycle
  always_ff @(posedge clk)
  begin
    if (state_q == DBG_ACCESS)
    begin
      if (dbg_csr_req_o)
        rdata_q <= dbg_csr_rdata_i;         // Value before the write
      else if (ctrl_space)
        rdata_q <= {31'd0, halt_q};
      else
        rdata_q <= '0;                      // Core running or unmapped
    end
  end

  ////////////////////
  // CSR port
  ////////////////////

  // Only while halted, else the write is dropped
  assign dbg_csr_req_o   = (state_q == DBG_ACCESS) & csr_space & dbg_stall_o;
  assign dbg_csr_we_o    = dbginf_we_i;
  assign dbg_csr_addr_o  = dbginf_addr_i[11:0];
  assign dbg_csr_wdata_o = dbginf_data_i;

  assign dbginf_ack_o    = ack_q;
  assign dbginf_data_o   = rdata_q;

  // Accepted strobe gives a one cycle ack two cycles after the sampling edge
  a_ack_timing: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == DBG_IDLE && dbginf_strobe_i) |-> ##3 dbginf_ack_o ##1 !dbginf_ack_o)
    else $error("debug ack timing violated");

  a_csr_req_window: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_csr_req_o |-> (state_q == DBG_ACCESS) ##1 !dbg_csr_req_o)
    else $error("debug CSR request outside the access cycle");

endmodule

// File: cs_registers.sv
// CSR file with the core and debug access ports, instantiated by the control/status top level
`timescale 1ns/1ps

module cs_registers
#(
  parameter int unsigned n_ext_counters = 2
)
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Static ids for MHARTID
  input  core_csr_pkg::hart_id_t        core_id_i,
  input  core_csr_pkg::hart_id_t        cluster_id_i,

  // Execute stage port
  input  logic                          csr_access_i,
  input  core_csr_pkg::csr_op_e         csr_op_i,
  input  core_csr_pkg::csr_addr_t       csr_addr_i,
  input  core_csr_pkg::word_t           csr_wdata_i,
  output core_csr_pkg::word_t           csr_rdata_o,

  // Debug unit port
  input  logic                          dbg_csr_req_i,
  input  logic                          dbg_csr_we_i,
  input  core_csr_pkg::csr_addr_t       dbg_csr_addr_i,
  input  core_csr_pkg::word_t           dbg_csr_wdata_i,
  output core_csr_pkg::word_t           dbg_csr_rdata_o,

  // Counter event sources
  input  logic                          data_req_i,
  input  logic                          data_gnt_i,
  input  logic                          data_we_i,
  input  logic [n_ext_counters-1:0]     ext_perf_counters_i
);

  import core_csr_pkg::*;

  localparam int unsigned n_cnt     = n_ext_counters + 3;
  localparam word_t       pcer_mask = word_t'((32'd1 << n_cnt) - 32'd1);  // Implemented bits

  logic              access;       // Selected port active
  csr_op_e           op;
  csr_addr_t         addr;
  word_t             wdata;
  word_t             rdata;        // Value before the operation
  word_t             new_value;
  logic              writable;     // Mapped and not read only
  logic              csr_we;
  word_t             mscratch_q;
  word_t             pcer_q;
  logic [n_cnt-1:0]  cnt_we;
  word_t [n_cnt-1:0] cnt_values;

  if (n_ext_counters < 1 || n_ext_counters > MAX_EXT_CNT)
  begin : g_bad_ext_cnt
    $error("n_ext_counters must be between 1 and MAX_EXT_CNT");
  end

  // Counter index to CSR address
  function automatic csr_addr_t cnt_addr(int unsigned idx);
    case (idx)
      0:       return CSR_PCCR_CYCLE;
      1:       return CSR_PCCR_LOAD;
      2:       return CSR_PCCR_STORE;
      default: return csr_addr_t'(CSR_PCCR_EXT0 + idx - 3);
    endcase
  endfunction

  ////////////////////
  // Port arbitration
  ////////////////////

  // Debug request owns the port for its single cycle
  assign access = dbg_csr_req_i | csr_access_i;
  assign addr   = dbg_csr_req_i ? dbg_csr_addr_i  : csr_addr_i;
  assign wdata  = dbg_csr_req_i ? dbg_csr_wdata_i : csr_wdata_i;
  assign op     = dbg_csr_req_i ? (dbg_csr_we_i ? CSR_OP_WRITE : CSR_OP_NONE) : csr_op_i;

  ////////////////////
  // Read mux
  ////////////////////

  always_comb
  begin
    rdata    = '0;   // Unmapped reads as zero
    writable = 1'b0;
    case (addr)
      CSR_MSCRATCH:
      begin
        rdata    = mscratch_q;
        writable = 1'b1;
      end
      CSR_MHARTID: rdata = {22'd0, cluster_id_i, core_id_i};  // Read only
      CSR_PCER:
      begin
        rdata    = pcer_q;
        writable = 1'b1;
      end
      default: ;
    endcase
    for (int i = 0; i < n_cnt; i++)
    begin
      if (addr == cnt_addr(i))
      begin
        rdata    = cnt_values[i];
        writable = 1'b1;
      end
    end
  end

  assign csr_rdata_o     = rdata;
  assign dbg_csr_rdata_o = rdata;   // Debug sees the same mux

  ////////////////////
  // Write path
  ////////////////////

  always_comb
  begin
    case (op)
      CSR_OP_WRITE: new_value = wdata;
      CSR_OP_SET:   new_value = rdata | wdata;
      CSR_OP_CLEAR: new_value = rdata & ~wdata;
      default:      new_value = rdata;
    endcase
  end

  assign csr_we = access & (op != CSR_OP_NONE) & writable;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      mscratch_q <= '0;
      pcer_q     <= '0;
    end
    else if (csr_we)
    begin
      if (addr == CSR_MSCRATCH)
        mscratch_q <= new_value;
      if (addr == CSR_PCER)
        pcer_q <= new_value & pcer_mask;  // Unused enables stay 0
    end
  end

  // One write strobe per counter
  always_comb
  begin
    for (int i = 0; i < n_cnt; i++)
      cnt_we[i] = csr_we & (addr == cnt_addr(i));
  end

  perf_counters
  #(
    .n_ext_counters      ( n_ext_counters      )
  )
  i_perf_counters
  (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .pcer_i              ( pcer_q              ),
    .data_req_i          ( data_req_i          ),
    .data_gnt_i          ( data_gnt_i          ),
    .data_we_i           ( data_we_i           ),
    .ext_perf_counters_i ( ext_perf_counters_i ),
    .cnt_we_i            ( cnt_we              ),
    .cnt_wdata_i         ( new_value           ),
    .cnt_values_o        ( cnt_values          )
  );

  // Debug only accesses while the core is halted, so the ports never collide
  a_port_excl: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_csr_req_i |-> !csr_access_i)
    else $error("core CSR access during a debug CSR access");

endmodule

// File: perf_counters.sv
// Performance counter bank fed by data bus events and external pulses, instantiated by the CSR file
`timescale 1ns/1ps

module perf_counters
#(
  parameter int unsigned n_ext_counters = 2
)
(
  input  logic                                      clk,
  input  logic                                      rst_n,

  input  core_csr_pkg::word_t                       pcer_i,         // Enable mask

  // Observed data bus
  input  logic                                      data_req_i,
  input  logic                                      data_gnt_i,
  input  logic                                      data_we_i,

  input  logic [n_ext_counters-1:0]                 ext_perf_counters_i,

  // CSR write path
  input  logic [n_ext_counters+2:0]                 cnt_we_i,       // One strobe per counter
  input  core_csr_pkg::word_t                       cnt_wdata_i,

  output core_csr_pkg::word_t [n_ext_counters+2:0]  cnt_values_o
);

  import core_csr_pkg::*;

  localparam int unsigned n_cnt = n_ext_counters + 3;  // Cycle, load, store, externals

  logic              load_evt;
  logic              store_evt;
  logic [n_cnt-1:0]  evt;          // Per counter increment request
  word_t [n_cnt-1:0] cnt_q;

  ////////////////////
  // Event derivation
  ////////////////////

  // Granted transfer, split by direction
  assign load_evt  = data_req_i & data_gnt_i & ~data_we_i;
  assign store_evt = data_req_i & data_gnt_i &  data_we_i;

  // Same bit order as PCER
  assign evt = {ext_perf_counters_i, store_evt, load_evt, 1'b1};  // Bit 0 counts every cycle

  ////////////////////
  // Counter storage
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else
    begin
      for (int i = 0; i < n_cnt; i++)
      begin
        if (cnt_we_i[i])
          cnt_q[i] <= cnt_wdata_i;            // Software write beats the event
        else if (pcer_i[i] && evt[i])
          cnt_q[i] <= cnt_q[i] + 32'd1;       // Wraps at 32 bits
      end
    end
  end

  assign cnt_values_o = cnt_q;

  // Direction split must never flag both kinds at once
  a_evt_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_evt && store_evt))
    else $error("load and store event in the same cycle");

endmodule

// File: core_csr_pkg.sv
// Shared types, operation codes and the CSR address map, imported by every module of the slice
package core_csr_pkg;

  ////////////////////
  // Width types
  ////////////////////

  typedef logic [31:0] word_t;      // CSR data, counters, debug data bus
  typedef logic [11:0] csr_addr_t;  // CSR address space
  typedef logic [15:0] dbg_addr_t;  // Debug bus address
  typedef logic [4:0]  hart_id_t;   // Core or cluster id

  ////////////////////
  // Enums
  ////////////////////

  // CSR operation from the execute stage
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,  // Read only
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,  // OR data in
    CSR_OP_CLEAR = 2'b11   // Mask data out
  } csr_op_e;

  // Debug bus handshake states
  typedef enum logic [1:0] {
    DBG_IDLE    = 2'b00,  // Wait for strobe
    DBG_ACCESS  = 2'b01,  // CSR port or ctrl reg access
    DBG_ACK     = 2'b10,  // Ack being raised
    DBG_RELEASE = 2'b11   // Wait for strobe to drop
  } dbg_state_e;

  ////////////////////
  // CSR address map
  ////////////////////

  localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
  localparam csr_addr_t CSR_MHARTID    = 12'hF14;  // Read only, {cluster, core}

  // Performance counters
  localparam csr_addr_t CSR_PCCR_CYCLE = 12'h780;
  localparam csr_addr_t CSR_PCCR_LOAD  = 12'h781;
  localparam csr_addr_t CSR_PCCR_STORE = 12'h782;
  localparam csr_addr_t CSR_PCCR_EXT0  = 12'h783;  // Ext counter i at EXT0 + i

  // Counter enable mask
  // Bit 0 cycles, 1 loads, 2 stores, 3+i ext counter i
  localparam csr_addr_t CSR_PCER       = 12'h7A0;

  ////////////////////
  // Debug bus map
  ////////////////////

  localparam dbg_addr_t   DBG_ADDR_CTRL = 16'h0000;  // Halt control, bit 0 halt request
  localparam int unsigned DBG_CSR_BIT   = 15;        // Set selects CSR at addr[11:0]

  // Upper bound on external counters covered by PCER
  localparam int unsigned MAX_EXT_CNT   = 8;

endpackage
